/* life_top.f */
+incdir+bench
common/life_pkg.sv
life/gen_stage.sv
life/life_pipeline.sv
life/row_ram.sv
life/life_sequencer.sv
hdl/seed_lfsr.sv
hdl/life_top.sv
bench/life_tb.sv

/* Makefile */
# Verilator build and run of the Life engine testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module life_tb -Mdir obj_dir -f life_top.f
	./obj_dir/Vlife_tb | awk '{ print } /^Done: no errors$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* bench/life_model.svh */
////////////////////
// Reference model: torus Life step, seed LFSR, xorshift source
////////////////////
`ifndef LIFE_MODEL_SVH
`define LIFE_MODEL_SVH

////////////////////
// Model state
////////////////////
row_t        shadow [GRID_H];          // Expected grid, bit i is column i
row_t        lfsr_state = SEED_INIT;   // Tracks the DUT LFSR across seeds
gen_count_t  exp_total  = '0;          // Expected generation total
logic [31:0] rng        = 32'd41;      // xorshift state

// One generation on the torus, neighbours wrap both ways
function automatic void model_step();
	row_t nxt [GRID_H];
	int   n;
	for (int r = 0; r < GRID_H; r++) begin
		for (int c = 0; c < GRID_W; c++) begin
			n = 0;
			for (int dr = -1; dr <= 1; dr++) begin
				for (int dc = -1; dc <= 1; dc++) begin
					if (dr != 0 || dc != 0)   // Self not counted
						n += int'(shadow[(r + dr + GRID_H) % GRID_H][(c + dc + GRID_W) % GRID_W]);
				end
			end
			nxt[r][c] = (n == 3) || (n == 2 && shadow[r][c]);   // Birth on 3, survive on 2 or 3
		end
	end
	shadow = nxt;
endfunction

// Right-shift Galois step
function automatic row_t lfsr_advance(input row_t s);
	row_t shifted;
	shifted = s >> 1;
	return s[0] ? (shifted ^ SEED_MASK) : shifted;
endfunction

// 32-bit xorshift, 13/17/5
function automatic logic [31:0] xorshift_next();
	rng ^= rng << 13;
	rng ^= rng >> 17;
	rng ^= rng << 5;
	return rng;
endfunction

`endif

/* bench/life_tb.sv */
////////////////////
// Life engine testbench with clock, reset, command driver,
// stimulus, checks and timeout
////////////////////
`timescale 1ns/1ps
`default_nettype none

module life_tb import life_pkg::*; ();

	logic       clk;
	logic       reset;
	logic       req;
	life_cmd_t  cmd;
	logic       ack;
	row_t       rdata;
	gen_count_t gen_total;

	int   checks = 0;
	int   errors = 0;
	int   cmds   = 0;   // Commands issued for the timeout limit
	int   cycles;
	row_t rd_got;       // rdata captured at ack

	`include "life_model.svh"

	life_top u_life_top (
		.clk       (clk),
		.reset     (reset),
		.req       (req),
		.cmd       (cmd),
		.ack       (ack),
		.rdata     (rdata),
		.gen_total (gen_total)
	);

	initial begin   // 8 ns period
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Limit grows with each command
	initial begin
		cycles = 0;
		while (cycles <= 40 * cmds + 1000) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the DUT stopped answering commands after %0d cycles", cycles);
		$display("Done: errors found");
		$finish;
	end

	////////////////////
	// Checks and driver
	////////////////////
	task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("error %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// One four-phase command from a falling edge
	task automatic do_cmd(input life_op_e op, input row_idx_t row, input row_t data);
		@(posedge clk);
		req <= 1'b1;
		cmd <= '{op: op, row: row, data: data};
		cmds++;
		@(negedge clk);
		check_val("ack before req seen", 32'(ack), 32'd0);   // DUT samples req next edge
		while (!ack)
			@(negedge clk);
		rd_got = rdata;   // Read data valid with ack
		check_val("gen_total", gen_total, exp_total);
		@(posedge clk);
		req <= 1'b0;
		@(negedge clk);
		check_val("ack held until req drops", 32'(ack), 32'd1);
		@(negedge clk);
		check_val("ack after req drop", 32'(ack), 32'd0);   // Falls one cycle later
	endtask

	task automatic load_grid();
		for (int r = 0; r < GRID_H; r++)
			do_cmd(OP_LOAD, row_idx_t'(r), shadow[r]);
	endtask

	task automatic check_grid(input string what);
		for (int r = 0; r < GRID_H; r++) begin
			do_cmd(OP_READ, row_idx_t'(r), '0);
			check_val($sformatf("%s row %0d", what, r), 32'(rd_got), 32'(shadow[r]));
		end
	endtask

	task automatic step_grid();
		for (int g = 0; g < GENS; g++)
			model_step();
		exp_total += GENS;
		do_cmd(OP_STEP, '0, '0);
	endtask

	// Row r holds the state after r+1 advances
	task automatic seed_grid();
		for (int r = 0; r < GRID_H; r++) begin
			lfsr_state = lfsr_advance(lfsr_state);
			shadow[r]  = lfsr_state;
		end
		do_cmd(OP_SEED, '0, '0);
	endtask

	task automatic random_grid();
		for (int r = 0; r < GRID_H; r++)
			shadow[r] = row_t'(xorshift_next());
	endtask

	task automatic place_glider(input int r0, input int c0);
		for (int r = 0; r < GRID_H; r++)
			shadow[r] = '0;
		shadow[r0][(c0 + 1) % GRID_W]                = 1'b1;   // .X.
		shadow[(r0 + 1) % GRID_H][(c0 + 2) % GRID_W] = 1'b1;   // ..X
		for (int k = 0; k < 3; k++)
			shadow[(r0 + 2) % GRID_H][(c0 + k) % GRID_W] = 1'b1;   // XXX
	endtask

	////////////////////
	// Stimulus
	////////////////////
	initial begin
		reset = 1'b1;
		req   = 1'b0;
		cmd   = '0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_val("ack after reset", 32'(ack), 32'd0);
		check_val("gen_total after reset", gen_total, 32'd0);

		random_grid();   // Plain load and read back
		load_grid();
		check_grid("loaded");

		place_glider(GRID_H - 2, GRID_W - 1);   // Straddles both edges
		load_grid();
		check_grid("glider start");
		for (int s = 0; s < 6; s++) begin
			step_grid();
			check_grid($sformatf("glider step %0d", s));
		end

		for (int t = 0; t < 3; t++) begin
			random_grid();
			load_grid();
			for (int s = 0; s < 3; s++) begin
				step_grid();
				check_grid($sformatf("random %0d step %0d", t, s));
			end
		end

		seed_grid();   // LFSR carries over into the second seed
		check_grid("first seed");
		seed_grid();
		check_grid("second seed");
		step_grid();
		check_grid("seeded step");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/life_top.sv */
////////////////////
// Life engine top level
////////////////////
`timescale 1ns/1ps
`default_nettype none

module life_top import life_pkg::*; (
	input  wire        clk,
	input  wire        reset,

	// Command port with four-phase req/ack
	input  wire        req,
	input  life_cmd_t  cmd,
	output logic       ack,
	output row_t       rdata,      // Valid while ack high after a read

	output gen_count_t gen_total
);

	////////////////////
	// Internal wires
	////////////////////
	row_idx_t  rd_addr;
	row_t      rd_data;     // One cycle after rd_addr
	row_wr_t   load_wr;     // Into the active bank
	row_wr_t   next_wr;     // Into the inactive bank
	logic      swap;
	row_beat_t in_beat;
	logic      seed_adv;
	row_t      seed_row;

	// Command decode and pass control
	life_sequencer u_life_sequencer (
		.clk       (clk),
		.reset     (reset),
		.req       (req),
		.cmd       (cmd),
		.rd_data   (rd_data),
		.next_wr   (next_wr),
		.seed_row  (seed_row),
		.ack       (ack),
		.rdata     (rdata),
		.gen_total (gen_total),
		.rd_addr   (rd_addr),
		.load_wr   (load_wr),
		.swap      (swap),
		.in_beat   (in_beat),
		.seed_adv  (seed_adv)
	);

	// Ping-pong row banks
	row_ram u_row_ram (
		.clk     (clk),
		.reset   (reset),
		.rd_addr (rd_addr),
		.load_wr (load_wr),
		.next_wr (next_wr),
		.swap    (swap),
		.rd_data (rd_data)
	);

	// GENS stages of the Life rule
	life_pipeline u_life_pipeline (
		.clk     (clk),
		.reset   (reset),
		.in_beat (in_beat),
		.rd_data (rd_data),
		.next_wr (next_wr)
	);

	seed_lfsr u_seed_lfsr (
		.clk      (clk),
		.reset    (reset),
		.seed_adv (seed_adv),
		.seed_row (seed_row)
	);

endmodule

`default_nettype wire

/* hdl/seed_lfsr.sv */
////////////////////
// Row-wide Galois LFSR for grid seeding
////////////////////
`timescale 1ns/1ps
`default_nettype none

module seed_lfsr import life_pkg::*; (
	input  wire  clk,
	input  wire  reset,
	input  wire  seed_adv,    // One advance per seeded row
	output row_t seed_row     // State after the advance
);

	row_t state;
	row_t shifted;

	// Right shift, taps applied when bit 0 falls out
	assign shifted = {1'b0, state[GRID_W-1:1]};

	always_ff @(posedge clk) begin
		if (reset)
			state <= SEED_INIT;
		else if (seed_adv)
			state <= state[0] ? (shifted ^ SEED_MASK) : shifted;
	end

	assign seed_row = state;   // Persists across seed commands

endmodule

`default_nettype wire

/* life/life_sequencer.sv */
////////////////////
// Command handshake, step and seed FSM, row addressing
// and the generation total
////////////////////
`timescale 1ns/1ps
`default_nettype none

module life_sequencer import life_pkg::*; (
	input  wire        clk,
	input  wire        reset,
	input  wire        req,
	input  life_cmd_t  cmd,
	input  row_t       rd_data,
	input  row_wr_t    next_wr,    // Watched to count finished rows
	input  row_t       seed_row,
	output logic       ack,
	output row_t       rdata,
	output gen_count_t gen_total,
	output row_idx_t   rd_addr,
	output row_wr_t    load_wr,
	output logic       swap,
	output row_beat_t  in_beat,
	output logic       seed_adv
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOAD,
		ST_READ,
		ST_SEED,
		ST_STEP_ISSUE,    // Reading rows into the pipeline
		ST_STEP_DRAIN,    // Waiting for the last writes
		ST_ACK_HOLD       // Ack high until req drops
	} seq_state_e;

	seq_state_e          state;
	logic [CNT_BITS-1:0] issue_cnt;   // Beats issued, or seed rows advanced
	logic [CNT_BITS-1:0] wr_cnt;      // Next-generation writes seen
	row_idx_t            pass_idx;    // Wrapped row index of this beat
	logic                seed_wr;

	////////////////////
	// Addressing
	////////////////////

	// Pass starts GENS rows above row 0
	assign pass_idx = row_idx_t'((GRID_H - GENS + int'(issue_cnt)) % GRID_H);

	assign rd_addr = (state == ST_STEP_ISSUE) ? pass_idx : cmd.row;  // Read cmd uses host row

	always_comb begin
		in_beat.valid = (state == ST_STEP_ISSUE);
		in_beat.first = (issue_cnt == '0);
		in_beat.idx   = pass_idx;
		in_beat.cells = '0;     // Filled from rd_data in the pipeline
	end

	// Seed writes trail each advance by one cycle
	assign seed_adv = (state == ST_SEED) && (issue_cnt != CNT_BITS'(GRID_H));
	assign seed_wr  = (state == ST_SEED) && (issue_cnt != '0);

	always_comb begin
		load_wr.en = (state == ST_LOAD) || seed_wr;
		if (state == ST_SEED) begin
			load_wr.addr = row_idx_t'(issue_cnt - 1'b1);
			load_wr.data = seed_row;
		end else begin
			load_wr.addr = cmd.row;
			load_wr.data = cmd.data;
		end
	end

	////////////////////
	// Command FSM
	////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= ST_IDLE;
			issue_cnt <= '0;
			wr_cnt    <= '0;
			ack       <= 1'b0;
			swap      <= 1'b0;
			gen_total <= '0;
		end else begin
			swap <= 1'b0;   // Single-cycle pulse
			case (state)
				ST_IDLE: begin
					if (req) begin
						issue_cnt <= '0;
						wr_cnt    <= '0;
						case (cmd.op)
							OP_LOAD: state <= ST_LOAD;
							OP_READ: state <= ST_READ;
							OP_SEED: state <= ST_SEED;
							OP_STEP: state <= ST_STEP_ISSUE;
							default: state <= ST_IDLE;
						endcase
					end
				end
				ST_LOAD, ST_READ: begin   // Write or read done this cycle
					ack   <= 1'b1;
					state <= ST_ACK_HOLD;
				end
				ST_SEED: begin
					issue_cnt <= issue_cnt + 1'b1;
					if (issue_cnt == CNT_BITS'(GRID_H)) begin   // Last row written now
						ack   <= 1'b1;
						state <= ST_ACK_HOLD;
					end
				end
				ST_STEP_ISSUE: begin
					issue_cnt <= issue_cnt + 1'b1;
					if (next_wr.en)
						wr_cnt <= wr_cnt + 1'b1;
					if (issue_cnt == CNT_BITS'(PASS_ROWS - 1))
						state <= ST_STEP_DRAIN;
				end
				ST_STEP_DRAIN: begin
					if (next_wr.en) begin
						wr_cnt <= wr_cnt + 1'b1;
						if (wr_cnt == CNT_BITS'(GRID_H - 1)) begin   // Grid complete
							swap      <= 1'b1;
							gen_total <= gen_total + gen_count_t'(GENS);
							ack       <= 1'b1;
							state     <= ST_ACK_HOLD;
						end
					end
				end
				ST_ACK_HOLD: begin
					if (!req) begin
						ack   <= 1'b0;
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Read data capture
	always_ff @(posedge clk) begin
		if (state == ST_READ)
			rdata <= rd_data;
	end

endmodule

`default_nettype wire

/* life/row_ram.sv */
////////////////////
// Two-bank row memory with bank swap
////////////////////
`timescale 1ns/1ps
`default_nettype none

module row_ram import life_pkg::*; (
	input  wire      clk,
	input  wire      reset,
	input  row_idx_t rd_addr,
	input  row_wr_t  load_wr,    // Host and seed writes
	input  row_wr_t  next_wr,    // Pipeline results
	input  wire      swap,
	output row_t     rd_data
);

	row_t mem [2][GRID_H];   // Bank, row
	logic active;            // Bank holding the current grid

	////////////////////
	// Bank select
	////////////////////
	always_ff @(posedge clk) begin
		if (reset)
			active <= 1'b0;
		else if (swap)
			active <= ~active;   // New generation becomes current
	end

	// Registered read and both write ports
	always_ff @(posedge clk) begin
		rd_data <= mem[active][rd_addr];
		if (load_wr.en)
			mem[active][load_wr.addr] <= load_wr.data;
		if (next_wr.en)
			mem[~active][next_wr.addr] <= next_wr.data;   // Other bank only
	end

endmodule

`default_nettype wire

/* life/life_pipeline.sv */
////////////////////
// Chain of generation stages from memory read to next-gen write
////////////////////
`timescale 1ns/1ps
`default_nettype none

module life_pipeline import life_pkg::*; (
	input  wire       clk,
	input  wire       reset,
	input  row_beat_t in_beat,    // Issued alongside rd_addr
	input  row_t      rd_data,
	output row_wr_t   next_wr
);

	row_beat_t beat_q;           // Aligned with rd_data
	row_beat_t chain [GENS+1];   // Stage inputs, last entry is final output

	// Match the memory read latency
	always_ff @(posedge clk) begin
		if (reset)
			beat_q <= '0;
		else
			beat_q <= in_beat;
	end

	// Pair beat header with the row just read
	assign chain[0] = '{
		valid: beat_q.valid,
		first: beat_q.first,
		idx:   beat_q.idx,
		cells: rd_data
	};

	////////////////////
	// Stages
	////////////////////
	for (genvar g = 0; g < GENS; g++) begin : g_stage
		gen_stage u_gen_stage (
			.clk      (clk),
			.reset    (reset),
			.in_beat  (chain[g]),
			.out_beat (chain[g+1])
		);
	end

	// Final beats land at their own row index
	assign next_wr = '{
		en:   chain[GENS].valid,
		addr: chain[GENS].idx,
		data: chain[GENS].cells
	};

endmodule

`default_nettype wire

/* life/gen_stage.sv */
////////////////////
// One Life generation over a three-row window
////////////////////
`timescale 1ns/1ps
`default_nettype none

module gen_stage import life_pkg::*; (
	input  wire       clk,
	input  wire       reset,
	input  row_beat_t in_beat,
	output row_beat_t out_beat    // Middle row STAGE_LAT cycles later
);

	// Beat header travelling beside the cell math
	typedef struct packed {
		logic     valid;
		logic     first;
		row_idx_t idx;
	} hdr_t;

	row_t                   win_old, win_mid;  // Window rows above the incoming one
	row_idx_t               mid_idx;
	logic [GRID_W-1:0][1:0] csum, csum_q;      // Three-row column sums
	row_t                   cur_q;             // Middle row aligned with csum_q
	row_t                   next_cells, cells_q;
	logic [1:0]             pass_cnt;          // Saturating count of beats seen
	logic [1:0]             eff_cnt;
	logic                   emit;
	hdr_t                   hdr_q [STAGE_LAT]; // Header delay line

	// First beat restarts the drop count
	assign eff_cnt = in_beat.first ? 2'd0 : pass_cnt;
	assign emit    = in_beat.valid && (eff_cnt >= 2'd2);

	always_comb begin
		for (int i = 0; i < GRID_W; i++)
			csum[i] = {1'b0, win_old[i]} + {1'b0, win_mid[i]} + {1'b0, in_beat.cells[i]};
	end

	////////////////////
	// Window and sums
	////////////////////
	always_ff @(posedge clk) begin
		if (in_beat.valid) begin   // Shift only on real rows
			win_old <= win_mid;
			win_mid <= in_beat.cells;
			mid_idx <= in_beat.idx;
		end
		csum_q  <= csum;
		cur_q   <= win_mid;
		cells_q <= next_cells;
	end

	// Nine-cell total with horizontal wrap and the rule
	always_comb begin
		int         l;
		int         r;
		logic [3:0] tot;
		for (int i = 0; i < GRID_W; i++) begin
			l   = (i == 0) ? GRID_W - 1 : i - 1;
			r   = (i == GRID_W - 1) ? 0 : i + 1;
			tot = {2'b00, csum_q[l]} + {2'b00, csum_q[i]} + {2'b00, csum_q[r]};
			next_cells[i] = (tot == 4'd3) || ((tot == 4'd4) && cur_q[i]);  // Self counted in tot
		end
	end

	////////////////////
	// Control
	////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			pass_cnt <= '0;
			for (int k = 0; k < STAGE_LAT; k++)
				hdr_q[k] <= '0;
		end else begin
			if (in_beat.valid)
				pass_cnt <= (eff_cnt == 2'd3) ? 2'd3 : eff_cnt + 2'd1;
			hdr_q[0].valid <= emit;
			hdr_q[0].first <= emit && (eff_cnt == 2'd2);   // First output of the pass
			hdr_q[0].idx   <= mid_idx;
			for (int k = 1; k < STAGE_LAT; k++)
				hdr_q[k] <= hdr_q[k-1];
		end
	end

	assign out_beat = '{
		valid: hdr_q[STAGE_LAT-1].valid,
		first: hdr_q[STAGE_LAT-1].first,
		idx:   hdr_q[STAGE_LAT-1].idx,
		cells: cells_q
	};

endmodule

`default_nettype wire

/* common/life_pkg.sv */
////////////////////
// Grid sizes, row and beat types, command struct and opcodes
////////////////////
`default_nettype none

package life_pkg;

	////////////////////
	// Grid geometry
	////////////////////
	localparam int GRID_W    = 16;                  // Cells per row
	localparam int GRID_H    = 16;                  // Rows per grid
	localparam int ROW_BITS  = $clog2(GRID_H);      // Row index width
	localparam int GENS      = 2;                   // Generations per step pass
	localparam int STAGE_LAT = 2;                   // Beat in to result out, per stage

	// Pass length and counter width
	localparam int PASS_ROWS = GRID_H + 2 * GENS;   // Extra rows at both ends for vertical wrap
	localparam int CNT_BITS  = $clog2(PASS_ROWS + 1);

	// Seed generator
	localparam logic [GRID_W-1:0] SEED_INIT = 16'hACE1;
	localparam logic [GRID_W-1:0] SEED_MASK = 16'hB400;   // Galois taps

	////////////////////
	// Types
	////////////////////
	typedef logic [GRID_W-1:0]   row_t;         // Bit i is column i
	typedef logic [ROW_BITS-1:0] row_idx_t;
	typedef logic [31:0]         gen_count_t;

	typedef enum logic [1:0] {
		OP_LOAD,    // Write one row
		OP_READ,    // Read one row
		OP_STEP,    // GENS generations
		OP_SEED     // Fill grid from LFSR
	} life_op_e;

	typedef struct packed {
		life_op_e op;
		row_idx_t row;
		row_t     data;     // Load data only
	} life_cmd_t;

	// One row travelling down the pipeline
	typedef struct packed {
		logic     valid;
		logic     first;    // First beat of a pass
		row_idx_t idx;
		row_t     cells;
	} row_beat_t;

	typedef struct packed {
		logic     en;
		row_idx_t addr;
		row_t     data;
	} row_wr_t;

endpackage

`default_nettype wire
